// File: common/bus_pkg.sv
// Wishbone bus widths and lockstep copy-depth enum
package bus_pkg;

  // Word address width, 256 words addressable
  localparam int unsigned ADDR_W = 8;

  // Data word width
  localparam int unsigned DATA_W = 32;

  // One select bit per byte lane
  localparam int unsigned SEL_W = DATA_W / 8;

  // How much of a lockstep pair is copied or compared
  //   COPY_FULL    responses and read data copied, write data compared
  //   COPY_NO_DATA control only, no read data copy, no write data compare
  typedef enum logic {
    COPY_FULL    = 1'b0,
    COPY_NO_DATA = 1'b1
  } copy_depth_e;

endpackage

// File: common/engine_pkg.sv
// Copy engine opcode enum and FSM state enum
package engine_pkg;

  // Engine command
  typedef enum logic {
    OP_COPY = 1'b0, // Read src, write dst
    OP_FILL = 1'b1  // Write fill value to dst
  } opcode_e;

  // Engine FSM states
  typedef enum logic [1:0] {
    IDLE  = 2'd0, // Waiting for start
    READ  = 2'd1, // Source word read
    WRITE = 2'd2, // Destination word write
    DONE  = 2'd3  // One-cycle completion
  } eng_state_e;

endpackage

// File: verilog/wb_arbiter.sv
// Two-master round-robin Wishbone classic arbiter in front of one target
`timescale 1ns/1ps

module wb_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Master 0, host port
  input  logic                      m0_cyc,
  input  logic                      m0_stb,
  input  logic                      m0_we,
  input  logic [bus_pkg::ADDR_W-1:0] m0_adr,
  input  logic [bus_pkg::SEL_W-1:0]  m0_sel,
  input  logic [bus_pkg::DATA_W-1:0] m0_dat_w,
  output logic [bus_pkg::DATA_W-1:0] m0_dat_r,
  output logic                      m0_ack,
  // Master 1, copy engine
  input  logic                      m1_cyc,
  input  logic                      m1_stb,
  input  logic                      m1_we,
  input  logic [bus_pkg::ADDR_W-1:0] m1_adr,
  input  logic [bus_pkg::SEL_W-1:0]  m1_sel,
  input  logic [bus_pkg::DATA_W-1:0] m1_dat_w,
  output logic [bus_pkg::DATA_W-1:0] m1_dat_r,
  output logic                      m1_ack,
  // Target side
  output logic                      mem_cyc,
  output logic                      mem_stb,
  output logic                      mem_we,
  output logic [bus_pkg::ADDR_W-1:0] mem_adr,
  output logic [bus_pkg::SEL_W-1:0]  mem_sel,
  output logic [bus_pkg::DATA_W-1:0] mem_dat_w,
  input  logic [bus_pkg::DATA_W-1:0] mem_dat_r,
  input  logic                      mem_ack
);

  logic grant;     // 1 selects master 1
  logic owner_q;   // Master that held the bus last cycle
  logic lock_q;    // Owner had cyc high last cycle
  logic last_q;    // Master picked at the last fresh grant
  logic owner_cyc; // Owner still in its cycle
  logic hold;

  assign owner_cyc = owner_q ? m1_cyc : m0_cyc;
  assign hold      = lock_q & owner_cyc; // Grant frozen until owner drops cyc

  // Fresh grants are combinational so a lone requester starts at once
  always_comb begin
    if (hold) begin
      grant = owner_q;
    end else if (m0_cyc && m1_cyc) begin
      grant = ~last_q; // Tie goes to the one not served last
    end else begin
      grant = m1_cyc;  // Lone requester, or master 0 when nobody asks
    end
  end

  // Request mux towards the target
  assign mem_cyc   = grant ? m1_cyc   : m0_cyc;
  assign mem_stb   = grant ? m1_stb   : m0_stb;
  assign mem_we    = grant ? m1_we    : m0_we;
  assign mem_adr   = grant ? m1_adr   : m0_adr;
  assign mem_sel   = grant ? m1_sel   : m0_sel;
  assign mem_dat_w = grant ? m1_dat_w : m0_dat_w;

  // Responses only to the granted master, others keep waiting
  assign m0_ack   = ~grant & mem_ack;
  assign m1_ack   =  grant & mem_ack;
  assign m0_dat_r = grant ? '0 : mem_dat_r;
  assign m1_dat_r = grant ? mem_dat_r : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= 1'b0;
      lock_q  <= 1'b0;
      last_q  <= 1'b1; // Master 0 wins the first tie
    end else begin
      owner_q <= grant;
      lock_q  <= mem_cyc;
      if (mem_cyc && !hold) begin
        last_q <= grant; // Remember fresh grants only
      end
    end
  end

endmodule

// File: verilog/wb_sram.sv
// Word-addressed SRAM Wishbone target with byte selects and registered ack
`timescale 1ns/1ps

module wb_sram #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [bus_pkg::ADDR_W-1:0] adr,
  input  logic [bus_pkg::SEL_W-1:0]  sel,
  input  logic [bus_pkg::DATA_W-1:0] dat_w,
  output logic [bus_pkg::DATA_W-1:0] dat_r,
  output logic                       ack
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  logic [bus_pkg::DATA_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]           idx;
  logic                       access; // New access this cycle

  assign idx    = adr[IDX_W-1:0];
  assign access = cyc & stb & ~ack; // Ack low, so no repeat on held stb

  // One-cycle acknowledge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  // Array and read port, write lands on the ack edge
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we) begin
        for (int b = 0; b < bus_pkg::SEL_W; b++) begin
          if (sel[b]) begin
            mem[idx][8*b +: 8] <= dat_w[8*b +: 8]; // Byte lane b
          end
        end
      end else begin
        dat_r <= mem[idx]; // Valid together with ack
      end
    end
  end

endmodule

// File: copy_engine/copy_engine.sv
// Copy and fill engine FSM with Wishbone classic master port
`timescale 1ns/1ps

module copy_engine (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Command
  input  logic                       start,
  input  engine_pkg::opcode_e        opcode,
  input  logic [bus_pkg::ADDR_W-1:0] src_adr,
  input  logic [bus_pkg::ADDR_W-1:0] dst_adr,
  input  logic [bus_pkg::ADDR_W-1:0] len,
  input  logic [bus_pkg::DATA_W-1:0] fill_data,
  // Status
  output logic                       busy,
  output logic                       done,
  // Wishbone master
  output logic                       cyc,
  output logic                       stb,
  output logic                       we,
  output logic [bus_pkg::ADDR_W-1:0] adr,
  output logic [bus_pkg::SEL_W-1:0]  sel,
  output logic [bus_pkg::DATA_W-1:0] dat_w,
  input  logic [bus_pkg::DATA_W-1:0] dat_r,
  input  logic                       ack
);

  engine_pkg::eng_state_e state_q;
  engine_pkg::opcode_e    op_q;      // Latched opcode

  logic                       req_q;  // cyc and stb of the current access
  logic [bus_pkg::ADDR_W-1:0] src_q;  // Next source word
  logic [bus_pkg::ADDR_W-1:0] dst_q;  // Next destination word
  logic [bus_pkg::ADDR_W-1:0] cnt_q;  // Words still to write
  logic [bus_pkg::DATA_W-1:0] fill_q;
  logic [bus_pkg::DATA_W-1:0] buf_q;  // Word captured in READ

  // Control FSM
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= engine_pkg::IDLE;
      op_q    <= engine_pkg::OP_COPY;
      req_q   <= 1'b0;
      src_q   <= '0;
      dst_q   <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        engine_pkg::IDLE: begin
          if (start) begin
            op_q  <= opcode;
            src_q <= src_adr;
            dst_q <= dst_adr;
            cnt_q <= len;
            if (len == '0) begin
              state_q <= engine_pkg::DONE; // Nothing to move
            end else begin
              req_q   <= 1'b1;             // First access right away
              state_q <= (opcode == engine_pkg::OP_FILL) ? engine_pkg::WRITE
                                                         : engine_pkg::READ;
            end
          end
        end
        engine_pkg::READ: begin
          if (req_q && ack) begin
            req_q   <= 1'b0;               // Gap cycle lets the arbiter switch
            state_q <= engine_pkg::WRITE;
          end else begin
            req_q <= 1'b1;
          end
        end
        engine_pkg::WRITE: begin
          if (req_q && ack) begin
            req_q <= 1'b0;
            src_q <= src_q + 1'b1;
            dst_q <= dst_q + 1'b1;
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == 'd1) begin
              state_q <= engine_pkg::DONE; // Last word written
            end else if (op_q == engine_pkg::OP_COPY) begin
              state_q <= engine_pkg::READ;
            end
          end else begin
            req_q <= 1'b1;
          end
        end
        default: begin
          state_q <= engine_pkg::IDLE;     // DONE lasts one cycle
        end
      endcase
    end
  end

  // Payload registers, known write data for the lockstep compare
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q <= '0;
      buf_q  <= '0;
    end else begin
      if (state_q == engine_pkg::IDLE && start) begin
        fill_q <= fill_data;
      end
      if (state_q == engine_pkg::READ && req_q && ack) begin
        buf_q <= dat_r;
      end
    end
  end

  assign busy = (state_q == engine_pkg::READ) || (state_q == engine_pkg::WRITE);
  assign done = (state_q == engine_pkg::DONE);

  // Master request
  assign cyc   = req_q;
  assign stb   = req_q;
  assign we    = (state_q == engine_pkg::WRITE);
  assign adr   = (state_q == engine_pkg::WRITE) ? dst_q : src_q;
  assign sel   = '1; // Whole words only
  assign dat_w = (op_q == engine_pkg::OP_FILL) ? fill_q : buf_q;

endmodule

// File: copy_engine/bus_copy_sink.sv
// Lockstep comparator copying main responses to the shadow and flagging mismatches
`timescale 1ns/1ps

module bus_copy_sink #(
  parameter bus_pkg::copy_depth_e COPY_DEPTH    = bus_pkg::COPY_FULL, // Main to shadow
  parameter bus_pkg::copy_depth_e COMPARE_DEPTH = bus_pkg::COPY_FULL  // Shadow against main
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Main engine bus, observed only
  input  logic                       main_cyc,
  input  logic                       main_stb,
  input  logic                       main_we,
  input  logic [bus_pkg::ADDR_W-1:0] main_adr,
  input  logic [bus_pkg::SEL_W-1:0]  main_sel,
  input  logic [bus_pkg::DATA_W-1:0] main_dat_w,
  input  logic [bus_pkg::DATA_W-1:0] main_dat_r,
  input  logic                       main_ack,
  // Shadow engine bus, terminated here
  input  logic                       shd_cyc,
  input  logic                       shd_stb,
  input  logic                       shd_we,
  input  logic [bus_pkg::ADDR_W-1:0] shd_adr,
  input  logic [bus_pkg::SEL_W-1:0]  shd_sel,
  input  logic [bus_pkg::DATA_W-1:0] shd_dat_w,
  output logic [bus_pkg::DATA_W-1:0] shd_dat_r,
  output logic                       shd_ack,
  output logic                       fault_o
);

  logic ctrl_fault;
  logic data_fault;

  assign shd_ack = main_ack; // Handshake always mirrored

  // Control fields compared at every depth
  assign ctrl_fault = (main_cyc != shd_cyc) | (main_stb != shd_stb) |
                      (main_we  != shd_we)  | (main_adr != shd_adr) |
                      (main_sel != shd_sel);

  if (COPY_DEPTH == bus_pkg::COPY_FULL) begin : g_data_copy
    assign shd_dat_r = main_dat_r;
  end else begin : g_data_nocopy
    assign shd_dat_r = '0;
  end

  if (COMPARE_DEPTH == bus_pkg::COPY_FULL) begin : g_data_cmp
    assign data_fault = (main_dat_w != shd_dat_w);
  end else begin : g_data_nocmp
    assign data_fault = 1'b0;
  end

  // Registered flag, keeps the compare tree off the output path
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_o <= 1'b0;
    end else begin
      fault_o <= ctrl_fault | data_fault;
    end
  end

endmodule

// File: verilog/lockstep_copy_top.sv
// Top level with main and shadow copy engines, lockstep sink, arbiter and SRAM
`timescale 1ns/1ps

module lockstep_copy_top #(
  parameter bus_pkg::copy_depth_e COPY_DEPTH    = bus_pkg::COPY_FULL,
  parameter bus_pkg::copy_depth_e COMPARE_DEPTH = bus_pkg::COPY_FULL,
  parameter int unsigned          MEM_WORDS     = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Command, shared by both engines
  input  logic                       start,
  input  engine_pkg::opcode_e        opcode,
  input  logic [bus_pkg::ADDR_W-1:0] src_adr,
  input  logic [bus_pkg::ADDR_W-1:0] dst_adr,
  input  logic [bus_pkg::ADDR_W-1:0] len,
  input  logic [bus_pkg::DATA_W-1:0] fill_data,
  input  logic                       fault_inject_i, // Flips shadow address bit 0
  // Host Wishbone port
  input  logic                       host_cyc,
  input  logic                       host_stb,
  input  logic                       host_we,
  input  logic [bus_pkg::ADDR_W-1:0] host_adr,
  input  logic [bus_pkg::SEL_W-1:0]  host_sel,
  input  logic [bus_pkg::DATA_W-1:0] host_dat_w,
  output logic [bus_pkg::DATA_W-1:0] host_dat_r,
  output logic                       host_ack,
  // Status
  output logic                       busy,
  output logic                       done,
  output logic                       fault_o
);

  // Main engine bus
  logic                       main_cyc, main_stb, main_we, main_ack;
  logic [bus_pkg::ADDR_W-1:0] main_adr;
  logic [bus_pkg::SEL_W-1:0]  main_sel;
  logic [bus_pkg::DATA_W-1:0] main_dat_w, main_dat_r;
  // Shadow engine bus
  logic                       shd_cyc, shd_stb, shd_we, shd_ack;
  logic [bus_pkg::ADDR_W-1:0] shd_adr_raw, shd_adr;
  logic [bus_pkg::SEL_W-1:0]  shd_sel;
  logic [bus_pkg::DATA_W-1:0] shd_dat_w, shd_dat_r;
  // SRAM side
  logic                       mem_cyc, mem_stb, mem_we, mem_ack;
  logic [bus_pkg::ADDR_W-1:0] mem_adr;
  logic [bus_pkg::SEL_W-1:0]  mem_sel;
  logic [bus_pkg::DATA_W-1:0] mem_dat_w, mem_dat_r;

  assign shd_adr = shd_adr_raw ^ {{(bus_pkg::ADDR_W-1){1'b0}}, fault_inject_i};

  copy_engine u_main (
    .clk_i, .rst_ni, .start, .opcode, .src_adr, .dst_adr, .len, .fill_data,
    .busy, .done,
    .cyc(main_cyc), .stb(main_stb), .we(main_we), .adr(main_adr), .sel(main_sel),
    .dat_w(main_dat_w), .dat_r(main_dat_r), .ack(main_ack)
  );

  // Shadow status is redundant, only its bus is checked
  copy_engine u_shadow (
    .clk_i, .rst_ni, .start, .opcode, .src_adr, .dst_adr, .len, .fill_data,
    .busy(), .done(),
    .cyc(shd_cyc), .stb(shd_stb), .we(shd_we), .adr(shd_adr_raw), .sel(shd_sel),
    .dat_w(shd_dat_w), .dat_r(shd_dat_r), .ack(shd_ack)
  );

  bus_copy_sink #(.COPY_DEPTH(COPY_DEPTH), .COMPARE_DEPTH(COMPARE_DEPTH)) u_sink (
    .clk_i, .rst_ni,
    .main_cyc, .main_stb, .main_we, .main_adr, .main_sel, .main_dat_w,
    .main_dat_r, .main_ack,
    .shd_cyc, .shd_stb, .shd_we, .shd_adr, .shd_sel, .shd_dat_w,
    .shd_dat_r, .shd_ack, .fault_o
  );

  wb_arbiter u_arb (
    .clk_i, .rst_ni,
    .m0_cyc(host_cyc), .m0_stb(host_stb), .m0_we(host_we), .m0_adr(host_adr),
    .m0_sel(host_sel), .m0_dat_w(host_dat_w), .m0_dat_r(host_dat_r), .m0_ack(host_ack),
    .m1_cyc(main_cyc), .m1_stb(main_stb), .m1_we(main_we), .m1_adr(main_adr),
    .m1_sel(main_sel), .m1_dat_w(main_dat_w), .m1_dat_r(main_dat_r), .m1_ack(main_ack),
    .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_sel, .mem_dat_w, .mem_dat_r, .mem_ack
  );

  wb_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
    .clk_i, .rst_ni,
    .cyc(mem_cyc), .stb(mem_stb), .we(mem_we), .adr(mem_adr), .sel(mem_sel),
    .dat_w(mem_dat_w), .dat_r(mem_dat_r), .ack(mem_ack)
  );

endmodule

// File: tests/lockstep_properties.sv
// Bound assertions on arbiter handshake, arbiter grant hold and lockstep fault timing
`timescale 1ns/1ps

module lockstep_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic cyc,      // Request side of the watched bus
  input logic stb,
  input logic ack,
  input logic m0_cyc,   // Master 0 request at the arbiter
  input logic m1_cyc,   // Master 1 request at the arbiter
  input logic grant,
  input logic mismatch, // Request fields differ
  input logic fault
);

  // Target answers only a live request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack |-> cyc && stb)
    else $error("ack high without cyc and stb");

  // Master 1 keeps the bus while its cyc stays high
  grant_held_m1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (grant && m1_cyc) ##1 m1_cyc |-> grant)
    else $error("arbiter grant left master 1 during its cycle");

  // Master 0 keeps the bus while its cyc stays high
  grant_held_m0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!grant && m0_cyc) ##1 m0_cyc |-> !grant)
    else $error("arbiter grant left master 0 during its cycle");

  // Flag lags the compare by one cycle
  fault_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mismatch |=> fault)
    else $error("fault_o missed a request mismatch");

  fault_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !mismatch |=> !fault)
    else $error("fault_o high without a request mismatch");

endmodule

// Arbiter handshake and grant hold
bind wb_arbiter lockstep_properties u_arb_props (
  .clk_i(clk_i), .rst_ni(rst_ni),
  .cyc(mem_cyc), .stb(mem_stb), .ack(mem_ack),
  .m0_cyc(m0_cyc), .m1_cyc(m1_cyc), .grant(grant),
  .mismatch(1'b0), .fault(1'b0)
);

// Shadow handshake and fault timing on the sink
bind bus_copy_sink lockstep_properties u_sink_props (
  .clk_i(clk_i), .rst_ni(rst_ni),
  .cyc(shd_cyc), .stb(shd_stb), .ack(shd_ack),
  .m0_cyc(1'b0), .m1_cyc(1'b0), .grant(1'b0),
  .mismatch(({shd_cyc, shd_stb, shd_we, shd_adr, shd_sel} !=
             {main_cyc, main_stb, main_we, main_adr, main_sel}) ||
            ((COMPARE_DEPTH == bus_pkg::COPY_FULL) && (shd_dat_w != main_dat_w))),
  .fault(fault_o)
);

// File: tests/tb_lockstep_copy.sv
// Directed testbench for the lockstep copy subsystem with reference memory model and timeout
`timescale 1ns/1ps

module tb_lockstep_copy;

  localparam int AW = bus_pkg::ADDR_W;
  localparam int DW = bus_pkg::DATA_W;
  localparam int SW = bus_pkg::SEL_W;
  localparam int unsigned TIMEOUT_CYCLES = 20000; // Several times all tests together

  logic clk_i, rst_ni, start, fault_inject_i;
  engine_pkg::opcode_e opcode;
  logic [AW-1:0] src_adr, dst_adr, len, host_adr;
  logic [DW-1:0] fill_data, host_dat_w, host_dat_r;
  logic [SW-1:0] host_sel;
  logic host_cyc, host_stb, host_we, host_ack, busy, done, fault_o;

  logic [DW-1:0] model [2**AW]; // Expected SRAM contents
  int unsigned cycles = 0;
  int errors, checks, tests;
  logic fault_seen;             // fault_o sampled high during the last command

  lockstep_copy_top #(
    .COPY_DEPTH(bus_pkg::COPY_FULL), .COMPARE_DEPTH(bus_pkg::COPY_FULL), .MEM_WORDS(256)
  ) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i; // 8 ns period
  end

  // Hang guard
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, DUT never finished", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [DW-1:0] sel_mask(input logic [SW-1:0] sel);
    logic [DW-1:0] m;
    for (int b = 0; b < SW; b++) begin
      m[8*b +: 8] = {8{sel[b]}}; // Byte lane b
    end
    return m;
  endfunction

  task automatic note_failure(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  task automatic check_word(input string sig, input logic [AW-1:0] a,
                            input logic [DW-1:0] exp, input logic [DW-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s @%02h expected %08h actual %08h", $time, sig, a, exp, act);
    end
  endtask

  task automatic host_write(input logic [AW-1:0] a, input logic [SW-1:0] sel,
                            input logic [DW-1:0] d);
    logic [DW-1:0] m;
    m = sel_mask(sel);
    model[a] = (model[a] & ~m) | (d & m); // Only selected lanes change
    @(posedge clk_i);
    host_cyc   <= 1'b1;
    host_stb   <= 1'b1;
    host_we    <= 1'b1;
    host_adr   <= a;
    host_sel   <= sel;
    host_dat_w <= d;
    do begin
      @(negedge clk_i);
    end while (!host_ack); // Held off while the engine owns the bus
    @(posedge clk_i);
    host_cyc <= 1'b0;
    host_stb <= 1'b0;
    host_we  <= 1'b0;
  endtask

  task automatic host_read(input logic [AW-1:0] a, output logic [DW-1:0] d);
    @(posedge clk_i);
    host_cyc <= 1'b1;
    host_stb <= 1'b1;
    host_we  <= 1'b0;
    host_adr <= a;
    do begin
      @(negedge clk_i);
    end while (!host_ack);
    d = host_dat_r; // Valid with ack
    @(posedge clk_i);
    host_cyc <= 1'b0;
    host_stb <= 1'b0;
  endtask

  // Models the command, starts it and waits for done
  task automatic run_command(input engine_pkg::opcode_e op, input logic [AW-1:0] src,
                             input logic [AW-1:0] dst, input logic [AW-1:0] n,
                             input logic [DW-1:0] fill);
    for (int i = 0; i < int'(n); i++) begin
      model[AW'(dst + i)] = (op == engine_pkg::OP_FILL) ? fill : model[AW'(src + i)];
    end
    @(posedge clk_i);
    opcode    <= op;
    src_adr   <= src;
    dst_adr   <= dst;
    len       <= n;
    fill_data <= fill;
    start     <= 1'b1;
    @(posedge clk_i);
    start <= 1'b0;
    @(negedge clk_i);
    checks++;
    if (busy !== 1'b1) begin
      note_failure("busy did not rise after start");
    end
    fault_seen = fault_o;
    while (done !== 1'b1) begin
      @(negedge clk_i);
      fault_seen = fault_seen | fault_o;
    end
  endtask

  task automatic compare_memory();
    logic [DW-1:0] r;
    for (int a = 0; a < 2**AW; a++) begin
      host_read(AW'(a), r);
      check_word("host_dat_r", AW'(a), model[AW'(a)], r);
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    $display("%-12s done, %0d errors", name, errors - err0);
  endtask

  task automatic init_memory();
    logic [AW-1:0] a;
    for (int i = 0; i < 2**AW; i++) begin
      a = AW'(i);
      host_write(a, '1, {a, ~a, a ^ 8'h5a, 8'(a * 7)}); // Unique per address
    end
  endtask

  task automatic host_rw_test();
    logic [AW-1:0] a;
    logic [SW-1:0] s;
    logic [DW-1:0] d, r;
    int err0;
    err0 = errors;
    for (int i = 0; i < 16; i++) begin
      a = AW'($urandom);
      s = SW'($urandom);
      d = $urandom;
      host_write(a, s, d);
      host_read(a, r);
      check_word("host_dat_r", a, model[a], r);
    end
    finish_test("host_rw", err0);
  endtask

  task automatic fill_test();
    logic [AW-1:0] dst, n, a;
    logic [DW-1:0] r;
    int err0;
    err0 = errors;
    dst = AW'($urandom_range(32, 180));
    n   = AW'($urandom_range(1, 16));
    run_command(engine_pkg::OP_FILL, '0, dst, n, $urandom);
    if (fault_seen) begin
      note_failure("fault_o rose during a clean fill");
    end
    for (int i = 0; i < int'(n) + 2; i++) begin // One word either side as well
      a = AW'(dst - 1 + i);
      host_read(a, r);
      check_word("host_dat_r", a, model[a], r);
    end
    finish_test("fill", err0);
  endtask

  task automatic copy_test();
    logic [AW-1:0] src, dst, n;
    logic [DW-1:0] r;
    int err0;
    err0 = errors;
    src = AW'($urandom_range(0, 40));
    dst = AW'($urandom_range(128, 200));
    n   = AW'($urandom_range(1, 16));
    for (int i = 0; i < int'(n); i++) begin
      host_write(AW'(src + i), '1, $urandom); // Fresh source block
    end
    run_command(engine_pkg::OP_COPY, src, dst, n, '0);
    if (fault_seen) begin
      note_failure("fault_o rose during a clean copy");
    end
    for (int i = 0; i < int'(n); i++) begin
      host_read(AW'(dst + i), r);
      check_word("host_dat_r", AW'(dst + i), model[AW'(src + i)], r);
    end
    finish_test("copy", err0);
  endtask

  task automatic contention_test();
    logic [AW-1:0] a;
    logic [DW-1:0] r;
    int err0;
    err0 = errors;
    fork
      run_command(engine_pkg::OP_COPY, 8'h00, 8'h40, 8'd16, '0);
      begin
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        if (busy !== 1'b1) begin
          note_failure("copy not busy when host traffic started");
        end
        for (int i = 0; i < 8; i++) begin // Region away from the copy
          a = AW'(8'hf0 + i);
          host_write(a, '1, $urandom);
          host_read(a, r);
          check_word("host_dat_r", a, model[a], r);
        end
      end
    join
    if (fault_seen) begin
      note_failure("fault_o rose during the contended copy");
    end
    compare_memory();
    finish_test("contention", err0);
  endtask

  task automatic fault_test();
    int err0;
    err0 = errors;
    @(posedge clk_i);
    fault_inject_i <= 1'b1; // Shadow address bit 0 flipped
    run_command(engine_pkg::OP_FILL, '0, 8'h20, 8'd6, $urandom);
    if (!fault_seen) begin
      note_failure("fault_o never rose with fault injection on");
    end
    @(posedge clk_i);
    fault_inject_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    run_command(engine_pkg::OP_FILL, '0, 8'h30, 8'd6, $urandom);
    if (fault_seen) begin
      note_failure("fault_o rose after fault injection was released");
    end
    compare_memory(); // Shadow never reaches the SRAM
    finish_test("fault", err0);
  endtask

  initial begin
    void'($urandom(32'h2405));
    rst_ni         = 1'b0;
    start          = 1'b0;
    opcode         = engine_pkg::OP_COPY;
    src_adr        = '0;
    dst_adr        = '0;
    len            = '0;
    fill_data      = '0;
    fault_inject_i = 1'b0;
    host_cyc       = 1'b0;
    host_stb       = 1'b0;
    host_we        = 1'b0;
    host_adr       = '0;
    host_sel       = '0;
    host_dat_w     = '0;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    init_memory();
    host_rw_test();
    fill_test();
    copy_test();
    contention_test();
    fault_test();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: compile.f
common/bus_pkg.sv
common/engine_pkg.sv
verilog/wb_arbiter.sv
verilog/wb_sram.sv
copy_engine/copy_engine.sv
copy_engine/bus_copy_sink.sv
verilog/lockstep_copy_top.sv
tests/lockstep_properties.sv
tests/tb_lockstep_copy.sv

// File: Makefile
TOP := tb_lockstep_copy

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
